// ==== logic/arena_pkg.sv ====
package arena_pkg;

	//////////////////////////////////////////////////////////////////////
	// Types
	//////////////////////////////////////////////////////////////////////

	typedef logic [10:0] coord_t;

	typedef struct packed {
		coord_t x;
		coord_t y;
	} point_t;

	typedef enum logic [1:0] {
		STEP_HOLD  = 2'd0,
		STEP_PLUS  = 2'd1,
		STEP_MINUS = 2'd2
	} step_t;

	typedef logic [2:0] aim_t; // 0 is up and each +1 turns 45 degrees clockwise

	typedef struct packed {
		coord_t col;
		coord_t row;
		logic   hsync;
		logic   vsync;
		logic   visible;
	} scan_t;

	typedef struct packed {
		logic r;
		logic g;
		logic b;
	} rgb_t;

	localparam int unsigned NUM_TARGETS = 20;

	typedef logic [NUM_TARGETS-1:0] alive_t;

	//////////////////////////////////////////////////////////////////////
	// Scan timing of 800x600 inside 1040x666
	//////////////////////////////////////////////////////////////////////

	localparam coord_t H_TOTAL      = 11'd1040;
	localparam coord_t H_SYNC_START = 11'd919;
	localparam coord_t H_SYNC_END   = 11'd1039;
	localparam coord_t V_TOTAL      = 11'd666;
	localparam coord_t V_SYNC_START = 11'd659;
	localparam coord_t V_SYNC_END   = 11'd665;
	localparam coord_t WIN_LEFT     = 11'd104; // Window is open on all four edges
	localparam coord_t WIN_RIGHT    = 11'd904;
	localparam coord_t WIN_TOP      = 11'd23;
	localparam coord_t WIN_BOTTOM   = 11'd623;

	//////////////////////////////////////////////////////////////////////
	// Game
	//////////////////////////////////////////////////////////////////////

	localparam point_t HOME = '{x: 11'd500, y: 11'd500}; // Emitter centre

	localparam int unsigned BULLET_R = 10;
	localparam int unsigned BODY_R   = 20;

	localparam logic [23:0] BULLET_AREA = 24'(BULLET_R * BULLET_R);
	localparam logic [23:0] BODY_AREA   = 24'(BODY_R * BODY_R);
	localparam logic [23:0] HIT_DIST_SQ = 24'((BULLET_R + BODY_R) * (BULLET_R + BODY_R));

	localparam point_t TARGETS [NUM_TARGETS] = '{
		'{11'd150, 11'd150}, '{11'd200, 11'd150}, '{11'd250, 11'd150}, '{11'd300, 11'd150},
		'{11'd350, 11'd150}, '{11'd400, 11'd150}, '{11'd450, 11'd150}, '{11'd500, 11'd150},
		'{11'd550, 11'd150}, '{11'd600, 11'd150}, '{11'd650, 11'd150}, '{11'd700, 11'd150},
		'{11'd150, 11'd350}, '{11'd200, 11'd350}, '{11'd250, 11'd350}, '{11'd300, 11'd350},
		'{11'd350, 11'd350}, '{11'd400, 11'd350}, '{11'd450, 11'd350}, '{11'd600, 11'd350}
	};

	localparam logic [7:0] KEY_FIRE   = 8'h29;
	localparam logic [7:0] KEY_RECALL = 8'h15;
	localparam logic [7:0] KEY_CW     = 8'h74; // Right arrow
	localparam logic [7:0] KEY_CCW    = 8'h6B; // Left arrow

	localparam rgb_t COLOR_BULLET  = '{r: 1'b0, g: 1'b0, b: 1'b1};
	localparam rgb_t COLOR_EMITTER = '{r: 1'b1, g: 1'b0, b: 1'b0};
	localparam rgb_t COLOR_TARGET  = '{r: 1'b1, g: 1'b1, b: 1'b0};
	localparam rgb_t COLOR_BACK    = '{r: 1'b1, g: 1'b1, b: 1'b1};
	localparam rgb_t COLOR_BLANK   = '{r: 1'b0, g: 1'b0, b: 1'b0};

	// Squared distance of at most about 1.5M over the whole frame
	function automatic logic [23:0] dist_sq(point_t a, point_t b);
		logic signed [23:0] dx;
		logic signed [23:0] dy;
		dx = $signed({13'd0, a.x}) - $signed({13'd0, b.x});
		dy = $signed({13'd0, a.y}) - $signed({13'd0, b.y});
		return $unsigned(dx * dx + dy * dy);
	endfunction

endpackage

// ==== logic/vga_scan.sv ====
module vga_scan (
	input  logic             lclk,
	input  logic             reset,
	output arena_pkg::scan_t scan
);
	import arena_pkg::*;

	coord_t col;
	coord_t row;

	always_ff @(posedge lclk) begin
		if (reset) begin
			col <= '0;
			row <= '0;
		end else if (col == H_TOTAL - 11'd1) begin
			col <= '0;
			if (row == V_TOTAL - 11'd1)
				row <= '0;
			else
				row <= row + 11'd1;
		end else begin
			col <= col + 11'd1;
		end
	end

	// Decode straight from the counters
	always_comb begin
		scan.col     = col;
		scan.row     = row;
		scan.hsync   = !((col >= H_SYNC_START) && (col < H_SYNC_END)); // Low 919..1038
		scan.vsync   = !((row >= V_SYNC_START) && (row < V_SYNC_END)); // Low 659..664
		scan.visible = (col > WIN_LEFT) && (col < WIN_RIGHT) &&
		               (row > WIN_TOP) && (row < WIN_BOTTOM);
	end

endmodule

// ==== logic/bullet_control.sv ====
module bullet_control (
	input  logic              lclk,
	input  logic              reset,
	input  logic              step,
	input  logic [7:0]        kdata,
	output arena_pkg::point_t bullet,
	output logic              moving
);
	import arena_pkg::*;

	aim_t  aim;
	step_t dir_x;
	step_t dir_y;
	step_t aim_x;
	step_t aim_y;

	// One pixel along an axis
	function automatic coord_t advance(coord_t pos, step_t dir);
		case (dir)
			STEP_PLUS:  return pos + 11'd1;
			STEP_MINUS: return pos - 11'd1;
			default:    return pos;
		endcase
	endfunction

	function automatic step_t bounce(step_t dir, coord_t pos, coord_t lo, coord_t hi);
		if (dir == STEP_HOLD)
			return STEP_HOLD;
		else if (pos == lo)
			return STEP_PLUS;
		else if (pos == hi)
			return STEP_MINUS;
		else
			return dir;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Launch direction from the aim
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		aim_x = STEP_HOLD;
		aim_y = STEP_HOLD;
		case (aim)
			3'd0: aim_y = STEP_MINUS; // Up
			3'd1: begin
				aim_x = STEP_PLUS;
				aim_y = STEP_MINUS;
			end
			3'd2: aim_x = STEP_PLUS;  // Right
			3'd3: begin
				aim_x = STEP_PLUS;
				aim_y = STEP_PLUS;
			end
			3'd4: aim_y = STEP_PLUS;  // Down
			3'd5: begin
				aim_x = STEP_MINUS;
				aim_y = STEP_PLUS;
			end
			3'd6: aim_x = STEP_MINUS; // Left
			3'd7: begin
				aim_x = STEP_MINUS;
				aim_y = STEP_MINUS;
			end
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// Game step
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge lclk) begin
		if (reset) begin
			aim    <= '0;
			moving <= 1'b0;
			dir_x  <= STEP_HOLD;
			dir_y  <= STEP_HOLD;
			bullet <= HOME;
		end else if (step) begin
			if (kdata == KEY_CW)
				aim <= aim + 3'd1;
			else if (kdata == KEY_CCW)
				aim <= aim - 3'd1;

			if (kdata == KEY_FIRE)
				moving <= 1'b1;
			else if (kdata == KEY_RECALL)
				moving <= 1'b0;

			if (moving) begin
				bullet.x <= advance(bullet.x, dir_x);
				bullet.y <= advance(bullet.y, dir_y);
				dir_x    <= bounce(dir_x, bullet.x, WIN_LEFT, WIN_RIGHT); // Used next step
				dir_y    <= bounce(dir_y, bullet.y, WIN_TOP, WIN_BOTTOM);
			end else begin
				bullet <= HOME; // Parked on the emitter
				dir_x  <= aim_x;
				dir_y  <= aim_y;
			end
		end
	end

endmodule

// ==== logic/target_field.sv ====
module target_field (
	input  logic              lclk,
	input  logic              reset,
	input  arena_pkg::point_t bullet,
	input  logic              moving,
	output arena_pkg::alive_t alive
);
	import arena_pkg::*;

	alive_t hit;

	// All targets tested in parallel
	always_comb begin
		for (int i = 0; i < NUM_TARGETS; i++) begin
			hit[i] = moving && (dist_sq(bullet, TARGETS[i]) < HIT_DIST_SQ);
		end
	end

	// Flags only ever clear until the next reset
	always_ff @(posedge lclk) begin
		if (reset)
			alive <= '1;
		else
			alive <= alive & ~hit;
	end

endmodule

// ==== logic/pixel_render.sv ====
module pixel_render (
	input  logic              lclk,
	input  logic              reset,
	input  arena_pkg::scan_t  scan,
	input  arena_pkg::point_t bullet,
	input  arena_pkg::alive_t alive,
	output arena_pkg::rgb_t   color,
	output logic              hsync,
	output logic              vsync
);
	import arena_pkg::*;

	point_t pix;
	logic   on_bullet;
	logic   on_emitter;
	alive_t on_target;
	rgb_t   color_next;

	assign pix = '{x: scan.col, y: scan.row};

	//////////////////////////////////////////////////////////////////////
	// Shape tests
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		on_bullet  = dist_sq(pix, bullet) < BULLET_AREA;
		on_emitter = dist_sq(pix, HOME) < BODY_AREA;
		for (int i = 0; i < NUM_TARGETS; i++) begin
			on_target[i] = dist_sq(pix, TARGETS[i]) < BODY_AREA;
		end
	end

	// Bullet over emitter over targets
	always_comb begin
		if (!scan.visible)
			color_next = COLOR_BLANK;
		else if (on_bullet)
			color_next = COLOR_BULLET;
		else if (on_emitter)
			color_next = COLOR_EMITTER;
		else if (|(on_target & alive))
			color_next = COLOR_TARGET; // Dead targets fall through to background
		else
			color_next = COLOR_BACK;
	end

	// Color and syncs leave together one cycle after the scan
	always_ff @(posedge lclk) begin
		if (reset) begin
			color <= COLOR_BLANK;
			hsync <= 1'b1;
			vsync <= 1'b1;
		end else begin
			color <= color_next;
			hsync <= scan.hsync;
			vsync <= scan.vsync;
		end
	end

endmodule

// ==== logic/arena_top.sv ====
module arena_top (
	input  logic              lclk,
	input  logic              reset,
	input  logic              step,
	input  logic [7:0]        kdata,
	output logic              hsync,
	output logic              vsync,
	output arena_pkg::rgb_t   color,
	output arena_pkg::point_t bullet,
	output arena_pkg::alive_t alive
);
	import arena_pkg::*;

	scan_t scan;
	logic  moving;

	vga_scan u_scan (
		.lclk  (lclk),
		.reset (reset),
		.scan  (scan)
	);

	// Game state advanced on step
	bullet_control u_bullet (
		.lclk   (lclk),
		.reset  (reset),
		.step   (step),
		.kdata  (kdata),
		.bullet (bullet),
		.moving (moving)
	);

	target_field u_targets (
		.lclk   (lclk),
		.reset  (reset),
		.bullet (bullet),
		.moving (moving),
		.alive  (alive)
	);

	pixel_render u_render (
		.lclk   (lclk),
		.reset  (reset),
		.scan   (scan),
		.bullet (bullet),
		.alive  (alive),
		.color  (color),
		.hsync  (hsync),
		.vsync  (vsync)
	);

endmodule

// ==== verification/arena_checks.svh ====
`ifndef ARENA_CHECKS_SVH
`define ARENA_CHECKS_SVH

localparam int BULLET_SQ = int'(BULLET_R * BULLET_R);
localparam int BODY_SQ   = int'(BODY_R * BODY_R);
localparam int HIT_SQ    = int'((BULLET_R + BODY_R) * (BULLET_R + BODY_R));

// Gaps between steps and turn choices
function automatic logic [31:0] xorshift(logic [31:0] s);
	s ^= s << 13;
	s ^= s >> 17;
	s ^= s << 5;
	return s;
endfunction

function automatic int sq_dist(point_t a, point_t b);
	int dx;
	int dy;
	dx = int'(a.x) - int'(b.x);
	dy = int'(a.y) - int'(b.y);
	return dx * dx + dy * dy;
endfunction

// Twelve targets on the upper row, eight below
function automatic point_t target_pos(int i);
	point_t p;
	if (i < 12)
		p = '{x: coord_t'(150 + 50 * i), y: 11'd150};
	else if (i < 19)
		p = '{x: coord_t'(150 + 50 * (i - 12)), y: 11'd350};
	else
		p = '{x: 11'd600, y: 11'd350};
	return p;
endfunction

function automatic rgb_t ref_color(coord_t col, coord_t row, point_t b, alive_t a);
	point_t pix;
	logic   on_target;
	pix = '{x: col, y: row};
	on_target = 1'b0;
	for (int i = 0; i < int'(NUM_TARGETS); i++) begin
		if (a[i] && sq_dist(pix, target_pos(i)) < BODY_SQ)
			on_target = 1'b1;
	end
	if (col <= WIN_LEFT || col >= WIN_RIGHT || row <= WIN_TOP || row >= WIN_BOTTOM)
		return COLOR_BLANK;
	else if (sq_dist(pix, b) < BULLET_SQ)
		return COLOR_BULLET;
	else if (sq_dist(pix, HOME) < BODY_SQ)
		return COLOR_EMITTER;
	else if (on_target)
		return COLOR_TARGET;
	return COLOR_BACK;
endfunction

task automatic stop_run(string why);
	$display("%s", why);
	$display("Errors found");
	$fatal(1, "Simulation stopped");
endtask

task automatic rgb_equal(string name, rgb_t got, rgb_t want);
	if (got !== want)
		stop_run($sformatf("** Error: %s = %h, expected %h", name, got, want));
endtask

task automatic point_equal(string name, point_t got, point_t want);
	if (got !== want)
		stop_run($sformatf("** Error: %s = %h, expected %h", name, got, want));
endtask

task automatic alive_equal(string name, alive_t got, alive_t want);
	if (got !== want)
		stop_run($sformatf("** Error: %s = %h, expected %h", name, got, want));
endtask

task automatic bit_equal(string name, logic got, logic want);
	if (got !== want)
		stop_run($sformatf("** Error: %s = %h, expected %h", name, got, want));
endtask

`endif

// ==== verification/arena_tb.sv ====
module arena_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import arena_pkg::*;

	localparam int FRAME = int'(H_TOTAL) * int'(V_TOTAL);
	localparam int LIMIT = 3 * FRAME + 5000;

	logic        lclk;
	logic        reset;
	logic        step;
	logic [7:0]  kdata;
	logic        hsync;
	logic        vsync;
	rgb_t        color;
	point_t      bullet;
	alive_t      alive;

	coord_t      m_col;
	coord_t      m_row;
	aim_t        m_aim;
	logic        m_moving;
	step_t       m_dx;
	step_t       m_dy;
	point_t      m_bullet;
	alive_t      m_alive;
	point_t      exp_pix; // Scan position behind the current color
	rgb_t        exp_color;
	logic        exp_hsync;
	logic        exp_vsync;
	logic        m_stepped;
	logic        m_ready = 1'b0;
	logic [31:0] rng;
	int          cycles = 0;
	int          t7_count = 0;
	rgb_t        t7_color;

	`include "arena_checks.svh"

	arena_top u_dut (
		.lclk   (lclk),
		.reset  (reset),
		.step   (step),
		.kdata  (kdata),
		.hsync  (hsync),
		.vsync  (vsync),
		.color  (color),
		.bullet (bullet),
		.alive  (alive)
	);

	initial begin
		lclk = 1'b0;
		forever #20 lclk = ~lclk;
	end

	always @(posedge lclk) begin
		cycles++;
		if (cycles > LIMIT)
			stop_run("Timeout after three frames plus 5000 cycles");
	end

	//////////////////////////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////////////////////////

	task automatic game_step();
		point_t old;
		old = m_bullet;
		if (m_moving) begin
			m_bullet.x = old.x + ((m_dx == STEP_PLUS) ? 11'd1 : 11'd0)
			                   - ((m_dx == STEP_MINUS) ? 11'd1 : 11'd0);
			m_bullet.y = old.y + ((m_dy == STEP_PLUS) ? 11'd1 : 11'd0)
			                   - ((m_dy == STEP_MINUS) ? 11'd1 : 11'd0);
			if (m_dx != STEP_HOLD)
				m_dx = (old.x == WIN_LEFT) ? STEP_PLUS : (old.x == WIN_RIGHT) ? STEP_MINUS : m_dx;
			if (m_dy != STEP_HOLD)
				m_dy = (old.y == WIN_TOP) ? STEP_PLUS : (old.y == WIN_BOTTOM) ? STEP_MINUS : m_dy;
		end else begin
			m_bullet = HOME;
			m_dx = (m_aim inside {3'd1, 3'd2, 3'd3}) ? STEP_PLUS :
			       (m_aim inside {3'd5, 3'd6, 3'd7}) ? STEP_MINUS : STEP_HOLD;
			m_dy = (m_aim inside {3'd3, 3'd4, 3'd5}) ? STEP_PLUS :
			       (m_aim inside {3'd7, 3'd0, 3'd1}) ? STEP_MINUS : STEP_HOLD;
		end
		if (kdata == KEY_CW)
			m_aim = m_aim + 3'd1;
		else if (kdata == KEY_CCW)
			m_aim = m_aim - 3'd1;
		if (kdata == KEY_FIRE)
			m_moving = 1'b1; // Fire beats recall
		else if (kdata == KEY_RECALL)
			m_moving = 1'b0;
	endtask

	always @(posedge lclk) begin
		if (reset) begin
			m_col     = '0;
			m_row     = '0;
			m_aim     = '0;
			m_moving  = 1'b0;
			m_dx      = STEP_HOLD;
			m_dy      = STEP_HOLD;
			m_bullet  = HOME;
			m_alive   = '1;
			exp_pix   = '0;
			exp_color = COLOR_BLANK;
			exp_hsync = 1'b1;
			exp_vsync = 1'b1;
			m_stepped = 1'b0;
			m_ready   = 1'b1;
		end else begin
			exp_color = ref_color(m_col, m_row, m_bullet, m_alive);
			exp_hsync = !(m_col inside {[H_SYNC_START : H_SYNC_END - 11'd1]});
			exp_vsync = !(m_row inside {[V_SYNC_START : V_SYNC_END - 11'd1]});
			exp_pix   = '{x: m_col, y: m_row};
			for (int i = 0; i < int'(NUM_TARGETS); i++) begin
				if (m_moving && sq_dist(m_bullet, target_pos(i)) < HIT_SQ)
					m_alive[i] = 1'b0;
			end
			m_stepped = step;
			if (step)
				game_step();
			if (m_col == H_TOTAL - 11'd1) begin
				m_col = '0;
				m_row = (m_row == V_TOTAL - 11'd1) ? 11'd0 : m_row + 11'd1;
			end else begin
				m_col = m_col + 11'd1;
			end
		end
	end

	// Compare in mid-cycle
	always @(negedge lclk) begin
		if (m_ready) begin
			rgb_equal("color", color, exp_color);
			bit_equal("hsync", hsync, exp_hsync);
			bit_equal("vsync", vsync, exp_vsync);
			alive_equal("alive", alive, m_alive);
			if (m_stepped)
				point_equal("bullet", bullet, m_bullet);
			if (exp_pix == target_pos(7)) begin
				t7_color = color;
				t7_count++;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////////////////////////

	task automatic next_cycle();
		@(posedge lclk);
		#2;
	endtask

	task automatic press(logic [7:0] key);
		next_cycle();
		step  = 1'b1;
		kdata = key;
		next_cycle();
		step  = 1'b0;
		kdata = 8'h00;
		rng = xorshift(rng);
		repeat (rng[1:0]) next_cycle();
	endtask

	task automatic go_home();
		press(KEY_RECALL);
		press(8'h00); // Bullet parks on this step
	endtask

	task automatic fly_to(logic along_x, coord_t pos, output int moves);
		moves = 0;
		while ((along_x ? bullet.x : bullet.y) != pos) begin
			press(8'h00);
			moves++;
			if (moves > 1000)
				stop_run($sformatf("Bullet never reached position %0d", pos));
		end
	endtask

	// One frame of output at any alignment
	task automatic measure_sync();
		int   h_low;
		int   v_low;
		int   v_falls;
		logic v_prev;
		h_low   = 0;
		v_low   = 0;
		v_falls = 0;
		v_prev  = 1'b1;
		for (int n = 0; n < FRAME; n++) begin
			@(negedge lclk);
			h_low   += int'(!hsync);
			v_low   += int'(!vsync);
			v_falls += int'(v_prev && !vsync);
			v_prev   = vsync;
			if ((n + 1) % int'(H_TOTAL) == 0) begin
				if (h_low != 120)
					stop_run($sformatf("hsync was low for %0d cycles of a line", h_low));
				h_low = 0;
			end
		end
		if (v_low != 6 * int'(H_TOTAL) || v_falls != 1)
			stop_run($sformatf("vsync was low %0d cycles in %0d pulses", v_low, v_falls));
	endtask

	initial begin
		int     moves;
		int     seen;
		alive_t want;
		reset = 1'b1;
		step  = 1'b0;
		kdata = 8'h00;
		rng   = 32'hd7822016;
		repeat (8) @(posedge lclk);
		#2 reset = 1'b0;

		measure_sync(); // Idle image checked pixel by pixel meanwhile

		repeat (12) begin
			rng = xorshift(rng);
			press(rng[4] ? KEY_CW : KEY_CCW);
		end
		press(KEY_FIRE);
		repeat (60) press(8'h00);

		// Right wall bounce
		go_home();
		while (m_aim != 3'd2)
			press(KEY_CW);
		press(KEY_FIRE);
		fly_to(1'b1, WIN_RIGHT, moves);
		if (moves != 404)
			stop_run($sformatf("Bullet took %0d moves to the right edge", moves));
		press(8'h00);
		point_equal("bullet", bullet, point_t'{x: WIN_RIGHT + 11'd1, y: HOME.y});
		press(8'h00);
		point_equal("bullet", bullet, point_t'{x: WIN_RIGHT, y: HOME.y});

		// Straight up through target 7 and back
		go_home();
		while (m_aim != 3'd0)
			press(KEY_CW);
		press(KEY_FIRE);
		fly_to(1'b0, WIN_TOP, moves);
		fly_to(1'b0, 11'd200, moves);
		want    = '1;
		want[7] = 1'b0;
		alive_equal("alive", alive, want);

		go_home();
		point_equal("bullet", bullet, HOME);
		repeat (3) press(8'h00);
		point_equal("bullet", bullet, HOME);
		alive_equal("alive", alive, want);

		seen = t7_count;
		wait (t7_count != seen);
		rgb_equal("color", t7_color, COLOR_BACK);

		$display("No errors");
		$finish;
	end

endmodule

// ==== all.f ====
+incdir+verification
logic/arena_pkg.sv
logic/vga_scan.sv
logic/bullet_control.sv
logic/target_field.sv
logic/pixel_render.sv
logic/arena_top.sv
verification/arena_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= arena_tb
FILELIST  ?= all.f
BUILD_DIR ?= build
LOG       ?= sim.log
VFLAGS    ?= --binary --timing
PASS_TEXT ?= No errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qx "$(PASS_TEXT)" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
